/* fmap_pingpong_buffer.f */
logic/fmap_pkg.sv
logic/fmap_bank.sv
logic/fmap_bank_pair.sv
logic/fmap_producer_port.sv
logic/fmap_consumer_port.sv
logic/fmap_pingpong_buffer.sv
testbench/tb_clock_gen.sv
testbench/fmap_pingpong_buffer_assert.sv
testbench/tb_fmap_pingpong_buffer.sv

/* Bender.yml */
package:
  name: fmap_pingpong_buffer

sources:
  # package first, then the design bottom up.
  - files:
      - logic/fmap_pkg.sv
      - logic/fmap_bank.sv
      - logic/fmap_bank_pair.sv
      - logic/fmap_producer_port.sv
      - logic/fmap_consumer_port.sv
      - logic/fmap_pingpong_buffer.sv

  # testbench with the bound checker.
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/fmap_pingpong_buffer_assert.sv
      - testbench/tb_fmap_pingpong_buffer.sv

/* testbench/tb_fmap_pingpong_buffer.sv */
`timescale 1ns/1ns

module tb_fmap_pingpong_buffer;

	localparam int FMAP_SIZE = 28;
	localparam int DEPTH = FMAP_SIZE * FMAP_SIZE;
	// two full bank fills plus the short passes around them.
	localparam int STIM_CYCLES = 2 * DEPTH + 128;
	localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES + 100;

	logic                    clk;
	logic                    arst_n;
	fmap_pkg::producer_req_t prod;
	fmap_pkg::fmap_word_t    prod_rdata;
	fmap_pkg::consumer_req_t cons;
	fmap_pkg::fmap_word_t    cons_rdata_a;
	fmap_pkg::fmap_word_t    cons_rdata_b;
	logic                    swap;
	fmap_pkg::bank_sel_t     sel;

	logic [31:0] lcg_state;
	int          cycle_count;
	int          timeout_count;

	tb_clock_gen i_tb_clock_gen (
		.clk    (clk),
		.arst_n (arst_n)
	);

	fmap_pingpong_buffer #(
		.FMAP_SIZE (FMAP_SIZE)
	) i_fmap_pingpong_buffer (
		.clk          (clk),
		.arst_n       (arst_n),
		.prod         (prod),
		.prod_rdata   (prod_rdata),
		.cons         (cons),
		.cons_rdata_a (cons_rdata_a),
		.cons_rdata_b (cons_rdata_b),
		.swap         (swap),
		.sel          (sel)
	);

	// ######################################
	// helpers
	// ######################################

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic draw_addr(output fmap_pkg::fmap_addr_t addr);
		lcg_state = lcg_next(lcg_state);
		addr = fmap_pkg::fmap_addr_t'(lcg_state[31:16] % DEPTH);
	endtask

	task automatic draw_word(output fmap_pkg::fmap_word_t word);
		lcg_state = lcg_next(lcg_state);
		word = lcg_state;
	endtask

	// two different addresses, each enable low now and then.
	task automatic draw_cons(output fmap_pkg::consumer_req_t c);
		fmap_pkg::fmap_addr_t step;
		c = '0;
		lcg_state = lcg_next(lcg_state);
		c.re_a = (lcg_state[19:16] != 4'd0);
		c.re_b = (lcg_state[23:20] != 4'd0);
		draw_addr(c.addr_a);
		draw_addr(step);
		c.addr_b = fmap_pkg::fmap_addr_t'((c.addr_a + 1 + step % (DEPTH - 1)) % DEPTH);
	endtask

	task automatic drive_cycle(input fmap_pkg::producer_req_t p,
		input fmap_pkg::consumer_req_t c, input logic s);
		@(posedge clk);
		prod <= p;
		cons <= c;
		swap <= s;
	endtask

	// producer writes every address once, reading back the previous one.
	task automatic fill_bank(input logic with_reads);
		fmap_pkg::producer_req_t p;
		fmap_pkg::consumer_req_t c;
		for (int a = 0; a < DEPTH; a++)
		begin
			p = '0;
			c = '0;
			p.we = 1'b1;
			p.waddr = fmap_pkg::fmap_addr_t'(a);
			draw_word(p.wdata);
			if (a > 0)
			begin
				p.re = 1'b1;
				p.raddr = fmap_pkg::fmap_addr_t'(a - 1);
			end
			if (with_reads)
			begin
				draw_cons(c);
			end
			drive_cycle(p, c, 1'b0);
		end
	endtask

	task automatic rewrite_same_address();
		fmap_pkg::producer_req_t p;
		repeat (16)
		begin
			p = '0;
			p.we = 1'b1;
			p.re = 1'b1;
			draw_addr(p.waddr);
			p.raddr = p.waddr;
			draw_word(p.wdata);
			drive_cycle(p, '0, 1'b0);
		end
		drive_cycle('0, '0, 1'b0);
	endtask

	// reads issued with the swap still go to the old banks.
	task automatic swap_cycle(input logic with_cons_read);
		fmap_pkg::producer_req_t p;
		fmap_pkg::consumer_req_t c;
		p = '0;
		c = '0;
		p.re = 1'b1;
		draw_addr(p.raddr);
		if (with_cons_read)
		begin
			draw_cons(c);
		end
		drive_cycle(p, c, 1'b1);
	endtask

	task automatic mixed_traffic(input int cycles);
		fmap_pkg::producer_req_t p;
		fmap_pkg::consumer_req_t c;
		repeat (cycles)
		begin
			p = '0;
			p.we = 1'b1;
			p.re = 1'b1;
			draw_addr(p.waddr);
			draw_addr(p.raddr);
			draw_word(p.wdata);
			draw_cons(c);
			drive_cycle(p, c, 1'b0);
		end
	endtask

	task automatic report_and_finish();
		int failures;
		failures = i_fmap_pingpong_buffer.i_fmap_pingpong_buffer_assert.fail_count;
		$display("assertion failures: %0d, timeouts: %0d", failures, timeout_count);
		if (failures == 0 && timeout_count == 0)
		begin
			$display("TESTS PASSED");
		end
		else
		begin
			$display("TESTS FAILED");
		end
		$finish;
	endtask

	// ######################################
	// stimulus and timeout
	// ######################################

	initial
	begin
		prod = '0;
		cons = '0;
		swap = 1'b0;
		lcg_state = 32'hfe0950dc;
		cycle_count = 0;
		timeout_count = 0;
		wait (arst_n === 1'b1);
		repeat (3) drive_cycle('0, '0, 1'b0);
		fill_bank(1'b0);
		rewrite_same_address();
		swap_cycle(1'b0);
		fill_bank(1'b1);
		swap_cycle(1'b1);
		mixed_traffic(64);
		repeat (4) drive_cycle('0, '0, 1'b0);
		report_and_finish();
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			timeout_count = timeout_count + 1;
			$display("run did not finish within %0d cycles", TIMEOUT_CYCLES);
			report_and_finish();
		end
	end

endmodule

/* testbench/fmap_pingpong_buffer_assert.sv */
`timescale 1ns/1ns

module fmap_pingpong_buffer_assert #(
	parameter int FMAP_SIZE = 28
) (
	input logic                    clk,
	input logic                    arst_n,
	input fmap_pkg::producer_req_t prod,
	input fmap_pkg::fmap_word_t    prod_rdata,
	input fmap_pkg::consumer_req_t cons,
	input fmap_pkg::fmap_word_t    cons_rdata_a,
	input fmap_pkg::fmap_word_t    cons_rdata_b,
	input logic                    swap,
	input fmap_pkg::bank_sel_t     sel
);

	localparam int DEPTH = FMAP_SIZE * FMAP_SIZE;

	int fail_count;

	fmap_pkg::fmap_word_t shadow [2][DEPTH];
	fmap_pkg::bank_sel_t  sel_m;
	fmap_pkg::bank_sel_t  sel_m_d;
	fmap_pkg::bank_sel_t  cons_bank_m;
	// read data registers of each bank.
	fmap_pkg::fmap_word_t rdata_a_m [2];
	fmap_pkg::fmap_word_t rdata_b_m [2];
	fmap_pkg::fmap_word_t exp_prod;
	fmap_pkg::fmap_word_t exp_a;
	fmap_pkg::fmap_word_t exp_b;

	initial fail_count = 0;

	assign cons_bank_m = ~sel_m;

	// ######################################
	// shadow model
	// ######################################

	always_ff @(posedge clk)
	begin
		if (prod.we)
		begin
			shadow[sel_m][prod.waddr] <= prod.wdata;
		end
	end

	// reads see the shadow before this edge's write.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			sel_m     <= 1'b0;
			sel_m_d   <= 1'b0;
			rdata_a_m <= '{default: '0};
			rdata_b_m <= '{default: '0};
		end
		else
		begin
			if (swap)
			begin
				sel_m <= ~sel_m;
			end
			sel_m_d <= sel_m;
			if (prod.re)
			begin
				rdata_b_m[sel_m] <= shadow[sel_m][prod.raddr];
			end
			if (cons.re_a)
			begin
				rdata_a_m[cons_bank_m] <= shadow[cons_bank_m][cons.addr_a];
			end
			if (cons.re_b)
			begin
				rdata_b_m[cons_bank_m] <= shadow[cons_bank_m][cons.addr_b];
			end
		end
	end

	// each side picks the bank it owned one cycle earlier.
	assign exp_prod = rdata_b_m[sel_m_d];
	assign exp_a    = rdata_a_m[~sel_m_d];
	assign exp_b    = rdata_b_m[~sel_m_d];

	// ######################################
	// output checks
	// ######################################

	a_sel : assert property (@(posedge clk) disable iff (!arst_n) sel === sel_m)
	else
	begin
		fail_count++;
		$error("Mismatch at %0t: sel expected %0d, got %0d", $time, $sampled(sel_m),
			$sampled(sel));
	end

	a_prod_rdata : assert property (@(posedge clk) disable iff (!arst_n)
		prod_rdata === exp_prod)
	else
	begin
		fail_count++;
		$error("Mismatch at %0t: prod_rdata expected %h, got %h", $time,
			$sampled(exp_prod), $sampled(prod_rdata));
	end

	a_cons_rdata_a : assert property (@(posedge clk) disable iff (!arst_n)
		cons_rdata_a === exp_a)
	else
	begin
		fail_count++;
		$error("Mismatch at %0t: cons_rdata_a expected %h, got %h", $time,
			$sampled(exp_a), $sampled(cons_rdata_a));
	end

	a_cons_rdata_b : assert property (@(posedge clk) disable iff (!arst_n)
		cons_rdata_b === exp_b)
	else
	begin
		fail_count++;
		$error("Mismatch at %0t: cons_rdata_b expected %h, got %h", $time,
			$sampled(exp_b), $sampled(cons_rdata_b));
	end

	// ######################################
	// address range
	// ######################################

	a_addr_range : assert property (@(posedge clk) disable iff (!arst_n)
		(!prod.we || prod.waddr < DEPTH) && (!prod.re || prod.raddr < DEPTH) &&
		(!cons.re_a || cons.addr_a < DEPTH) && (!cons.re_b || cons.addr_b < DEPTH))
	else
	begin
		fail_count++;
		$error("an enabled address at %0t lies outside the feature map", $time);
	end

endmodule

bind fmap_pingpong_buffer fmap_pingpong_buffer_assert #(
	.FMAP_SIZE (FMAP_SIZE)
) i_fmap_pingpong_buffer_assert (
	.clk          (clk),
	.arst_n       (arst_n),
	.prod         (prod),
	.prod_rdata   (prod_rdata),
	.cons         (cons),
	.cons_rdata_a (cons_rdata_a),
	.cons_rdata_b (cons_rdata_b),
	.swap         (swap),
	.sel          (sel)
);

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen #(
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic arst_n
);

	// 4 ns period.
	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial
	begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		arst_n <= 1'b1;
	end

endmodule

/* logic/fmap_pingpong_buffer.sv */
`timescale 1ns/1ns

module fmap_pingpong_buffer #(
	parameter int FMAP_SIZE = 28
) (
	input  logic                    clk,
	input  logic                    arst_n,
	input  fmap_pkg::producer_req_t prod,
	output fmap_pkg::fmap_word_t    prod_rdata,
	input  fmap_pkg::consumer_req_t cons,
	output fmap_pkg::fmap_word_t    cons_rdata_a,
	output fmap_pkg::fmap_word_t    cons_rdata_b,
	input  logic                    swap,
	output fmap_pkg::bank_sel_t     sel
);

	fmap_pkg::bank_req_t [1:0] prod_bank_req;
	fmap_pkg::bank_req_t [1:0] cons_bank_req;
	fmap_pkg::bank_rsp_t [1:0] bank_rsp;

	// ######################################
	// producer side
	// ######################################

	fmap_producer_port i_fmap_producer_port (
		.clk           (clk),
		.arst_n        (arst_n),
		.prod          (prod),
		.swap          (swap),
		.sel           (sel),
		.prod_bank_req (prod_bank_req),
		.bank_rsp      (bank_rsp),
		.prod_rdata    (prod_rdata)
	);

	// ######################################
	// banks
	// ######################################

	fmap_bank_pair #(
		.FMAP_SIZE (FMAP_SIZE)
	) i_fmap_bank_pair (
		.clk           (clk),
		.arst_n        (arst_n),
		.prod_bank_req (prod_bank_req),
		.cons_bank_req (cons_bank_req),
		.bank_rsp      (bank_rsp)
	);

	// ######################################
	// consumer side
	// ######################################

	fmap_consumer_port i_fmap_consumer_port (
		.clk           (clk),
		.arst_n        (arst_n),
		.cons          (cons),
		.sel           (sel),
		.cons_bank_req (cons_bank_req),
		.bank_rsp      (bank_rsp),
		.cons_rdata_a  (cons_rdata_a),
		.cons_rdata_b  (cons_rdata_b)
	);

endmodule

/* logic/fmap_consumer_port.sv */
`timescale 1ns/1ns

module fmap_consumer_port (
	input  logic                      clk,
	input  logic                      arst_n,
	input  fmap_pkg::consumer_req_t   cons,
	input  fmap_pkg::bank_sel_t       sel,
	output fmap_pkg::bank_req_t [1:0] cons_bank_req,
	input  fmap_pkg::bank_rsp_t [1:0] bank_rsp,
	output fmap_pkg::fmap_word_t      cons_rdata_a,
	output fmap_pkg::fmap_word_t      cons_rdata_b
);

	fmap_pkg::bank_sel_t cons_bank;
	fmap_pkg::bank_sel_t sel_d;
	fmap_pkg::bank_sel_t cons_bank_d;

	// consumer always reads the bank the producer does not own.
	assign cons_bank = ~sel;

	// ######################################
	// delayed select
	// ######################################

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			sel_d <= 1'b0;
		end
		else
		begin
			sel_d <= sel;
		end
	end

	assign cons_bank_d = ~sel_d;

	// ######################################
	// request routing
	// ######################################

	// read A on port A, read B on port B.
	always_comb
	begin
		cons_bank_req = '0;
		cons_bank_req[cons_bank].re_a   = cons.re_a;
		cons_bank_req[cons_bank].addr_a = cons.addr_a;
		cons_bank_req[cons_bank].re_b   = cons.re_b;
		cons_bank_req[cons_bank].addr_b = cons.addr_b;
	end

	// data from the bank that served last cycle's reads.
	always_comb
	begin
		cons_rdata_a = bank_rsp[cons_bank_d].rdata_a;
		cons_rdata_b = bank_rsp[cons_bank_d].rdata_b;
	end

endmodule

/* logic/fmap_producer_port.sv */
`timescale 1ns/1ns

module fmap_producer_port (
	input  logic                      clk,
	input  logic                      arst_n,
	input  fmap_pkg::producer_req_t   prod,
	input  logic                      swap,
	output fmap_pkg::bank_sel_t       sel,
	output fmap_pkg::bank_req_t [1:0] prod_bank_req,
	input  fmap_pkg::bank_rsp_t [1:0] bank_rsp,
	output fmap_pkg::fmap_word_t      prod_rdata
);

	// select as seen by the read issued one cycle earlier.
	fmap_pkg::bank_sel_t sel_d;

	// ######################################
	// bank select
	// ######################################

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			sel <= 1'b0;
		end
		else if (swap)
		begin
			sel <= ~sel;
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			sel_d <= 1'b0;
		end
		else
		begin
			sel_d <= sel;
		end
	end

	// ######################################
	// request routing
	// ######################################

	// write on port A, read-back on port B.
	always_comb
	begin
		prod_bank_req = '0;
		prod_bank_req[sel].we_a    = prod.we;
		prod_bank_req[sel].addr_a  = prod.waddr;
		prod_bank_req[sel].wdata_a = prod.wdata;
		prod_bank_req[sel].re_b    = prod.re;
		prod_bank_req[sel].addr_b  = prod.raddr;
	end

	// response comes from the bank that took the read-back.
	assign prod_rdata = bank_rsp[sel_d].rdata_b;

endmodule

/* logic/fmap_bank_pair.sv */
`timescale 1ns/1ns

module fmap_bank_pair #(
	parameter int FMAP_SIZE = 28
) (
	input  logic                      clk,
	input  logic                      arst_n,
	input  fmap_pkg::bank_req_t [1:0] prod_bank_req,
	input  fmap_pkg::bank_req_t [1:0] cons_bank_req,
	output fmap_pkg::bank_rsp_t [1:0] bank_rsp
);

	fmap_pkg::bank_req_t [1:0] bank_req;

	// each bank is owned by one side only, so the other side contributes zeros.
	always_comb
	begin
		for (int i = 0; i < 2; i++)
		begin
			bank_req[i].we_a    = prod_bank_req[i].we_a    | cons_bank_req[i].we_a;
			bank_req[i].re_a    = prod_bank_req[i].re_a    | cons_bank_req[i].re_a;
			bank_req[i].addr_a  = prod_bank_req[i].addr_a  | cons_bank_req[i].addr_a;
			bank_req[i].wdata_a = prod_bank_req[i].wdata_a | cons_bank_req[i].wdata_a;
			bank_req[i].re_b    = prod_bank_req[i].re_b    | cons_bank_req[i].re_b;
			bank_req[i].addr_b  = prod_bank_req[i].addr_b  | cons_bank_req[i].addr_b;
		end
	end

	// ######################################
	// the two banks
	// ######################################

	for (genvar g = 0; g < 2; g++)
	begin : gen_bank
		fmap_bank #(
			.FMAP_SIZE (FMAP_SIZE)
		) i_fmap_bank (
			.clk    (clk),
			.arst_n (arst_n),
			.req    (bank_req[g]),
			.rsp    (bank_rsp[g])
		);
	end

endmodule

/* logic/fmap_bank.sv */
`timescale 1ns/1ns

module fmap_bank #(
	parameter int FMAP_SIZE = 28
) (
	input  logic                clk,
	input  logic                arst_n,
	input  fmap_pkg::bank_req_t req,
	output fmap_pkg::bank_rsp_t rsp
);

	// one word per map pixel.
	localparam int DEPTH = FMAP_SIZE * FMAP_SIZE;

	fmap_pkg::fmap_word_t mem [DEPTH];

	// ######################################
	// write port
	// ######################################

	always_ff @(posedge clk)
	begin
		if (req.we_a)
		begin
			mem[req.addr_a] <= req.wdata_a;
		end
	end

	// ######################################
	// read ports
	// ######################################

	// a read in the same cycle as a write sees the old word.
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rsp <= '0;
		end
		else
		begin
			if (req.re_a)
			begin
				rsp.rdata_a <= mem[req.addr_a];
			end
			if (req.re_b)
			begin
				rsp.rdata_b <= mem[req.addr_b];
			end
		end
	end

endmodule

/* logic/fmap_pkg.sv */
package fmap_pkg;

	// ######################################
	// widths
	// ######################################

	localparam int FMAP_DATA_W = 32;

	// covers maps up to 32 by 32.
	localparam int FMAP_ADDR_W = 10;

	typedef logic [FMAP_DATA_W-1:0] fmap_word_t;
	typedef logic [FMAP_ADDR_W-1:0] fmap_addr_t;

	// bank currently owned by the producer.
	typedef logic bank_sel_t;

	// ######################################
	// requests and responses
	// ######################################

	// previous layer: write and read-back.
	typedef struct packed {
		logic       we;
		logic       re;
		fmap_addr_t waddr;
		fmap_addr_t raddr;
		fmap_word_t wdata;
	} producer_req_t;

	// next layer: two independent reads.
	typedef struct packed {
		logic       re_a;
		logic       re_b;
		fmap_addr_t addr_a;
		fmap_addr_t addr_b;
	} consumer_req_t;

	// port A writes or reads, port B only reads.
	typedef struct packed {
		logic       we_a;
		logic       re_a;
		fmap_addr_t addr_a;
		fmap_word_t wdata_a;
		logic       re_b;
		fmap_addr_t addr_b;
	} bank_req_t;

	typedef struct packed {
		fmap_word_t rdata_a;
		fmap_word_t rdata_b;
	} bank_rsp_t;

endpackage
